// ==== rv_decode_pkg.sv ====
package rv_decode_pkg;

  // datapath widths
  localparam int unsigned xlen       = 64;
  localparam int unsigned inst_len   = 32;
  localparam int unsigned reg_addr_w = 5;
  localparam int unsigned csr_addr_w = 12;
  localparam int unsigned trap_len   = 16;

  // trap bus bit positions, aligned with the machine cause codes
  localparam int unsigned trap_illegal_inst = 2;
  localparam int unsigned trap_ebreak       = 3;
  localparam int unsigned trap_ecall_m      = 11;
  // mret has no cause code, it takes the top spare bit
  localparam int unsigned trap_mret         = 15;

  // base opcode map, bits [6:0]
  typedef enum logic [6:0] {
    opc_load      = 7'b0000011,
    opc_store     = 7'b0100011,
    opc_branch    = 7'b1100011,
    opc_jalr      = 7'b1100111,
    opc_jal       = 7'b1101111,
    opc_misc_mem  = 7'b0001111,
    opc_op_imm    = 7'b0010011,
    opc_op        = 7'b0110011,
    opc_system    = 7'b1110011,
    opc_auipc     = 7'b0010111,
    opc_lui       = 7'b0110111,
    opc_op_imm_32 = 7'b0011011,
    opc_op_32     = 7'b0111011
  } opcode_e;

  typedef enum logic [4:0] {
    alu_none, alu_add, alu_sub, alu_xor, alu_or, alu_and,
    alu_sll, alu_srl, alu_sra, alu_sllw, alu_srlw, alu_sraw,
    alu_slt, alu_sltu,
    alu_beq, alu_bne, alu_blt, alu_bge, alu_bltu, alu_bgeu
  } alu_op_e;

  // execute class, tells ex which result path to use
  typedef enum logic [3:0] {
    exc_none, exc_auipc, exc_lui, exc_jal, exc_jalr, exc_load, exc_store,
    exc_branch, exc_opimm, exc_opimm32, exc_op, exc_op32, exc_csr, exc_ebreak
  } exc_op_e;

  typedef enum logic [3:0] {
    mem_none, mem_lb, mem_lbu, mem_lh, mem_lhu, mem_lw, mem_lwu, mem_ld,
    mem_sb, mem_sh, mem_sw, mem_sd, mem_fencei
  } mem_op_e;

  typedef enum logic [2:0] {
    csr_none, csr_read, csr_write, csr_set, csr_clear
  } csr_op_e;

  // what fetch hands over
  typedef struct packed {
    logic [xlen-1:0]     pc;
    logic [inst_len-1:0] inst;
    logic [trap_len-1:0] trap;
  } fetch_pkt_t;

  // write-back target of a later stage
  typedef struct packed {
    logic [reg_addr_w-1:0] rd_addr;
    logic [xlen-1:0]       rd_data;
  } bypass_t;

  typedef struct packed {
    alu_op_e               alu_op;
    exc_op_e               exc_op;
    mem_op_e               mem_op;
    csr_op_e               csr_op;
    logic [reg_addr_w-1:0] rs1_idx;
    logic [reg_addr_w-1:0] rs2_idx;
    logic [reg_addr_w-1:0] rd_idx;
    logic [csr_addr_w-1:0] csr_idx;
    logic [xlen-1:0]       imm;
    logic                  csr_imm_valid;
    logic [xlen-1:0]       csr_imm;
    logic [trap_len-1:0]   trap;
  } dec_ctrl_t;

  // contents of the id/ex register
  typedef struct packed {
    logic                valid;
    logic [xlen-1:0]     pc;
    logic [inst_len-1:0] inst;
    dec_ctrl_t           ctrl;
    logic [xlen-1:0]     rs1_data;
    logic [xlen-1:0]     rs2_data;
  } id_ex_t;

endpackage

// ==== inst_field_decoder.sv ====
`timescale 1ns/1ps

module inst_field_decoder (
  input  logic [rv_decode_pkg::inst_len-1:0] inst_i,
  input  logic [rv_decode_pkg::trap_len-1:0] trap_i,
  output rv_decode_pkg::dec_ctrl_t           ctrl_o
);
  import rv_decode_pkg::*;

  opcode_e               opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic [reg_addr_w-1:0] rs1;
  logic                  fmt_r, fmt_i, fmt_s, fmt_b, fmt_u, fmt_j;
  logic                  illegal, sys_priv, is_ecall, is_ebreak, is_mret;
  logic                  is_csr, csr_uimm, need_rs1, need_rs2, need_rd;
  alu_op_e               alu_sel;
  exc_op_e               exc_sel;
  mem_op_e               mem_sel;
  csr_op_e               csr_sel;

  assign opcode = opcode_e'(inst_i[6:0]);
  assign funct3 = inst_i[14:12];
  assign funct7 = inst_i[31:25];
  assign rs1    = inst_i[19:15];

  // instruction formats, used for operand selection
  assign fmt_r = (opcode == opc_op) || (opcode == opc_op_32);
  assign fmt_i = (opcode == opc_load) || (opcode == opc_op_imm) ||
                 (opcode == opc_op_imm_32) || (opcode == opc_jalr) || (opcode == opc_system);
  assign fmt_s = (opcode == opc_store);
  assign fmt_b = (opcode == opc_branch);
  assign fmt_u = (opcode == opc_auipc) || (opcode == opc_lui);
  assign fmt_j = (opcode == opc_jal);
  // only the opcode is checked here
  assign illegal = !(fmt_r || fmt_i || fmt_s || fmt_b || fmt_u || fmt_j ||
                     (opcode == opc_misc_mem));

  assign sys_priv  = (opcode == opc_system) && (funct3 == 3'b000);
  assign is_ecall  = sys_priv && (inst_i[31:20] == 12'h000);
  assign is_ebreak = sys_priv && (inst_i[31:20] == 12'h001);
  assign is_mret   = sys_priv && (inst_i[31:20] == 12'h302);
  assign is_csr    = (opcode == opc_system) && (funct3[1:0] != 2'b00);
  // uimm forms reuse the rs1 field
  assign csr_uimm  = is_csr && funct3[2];

  assign need_rs1 = (fmt_r || fmt_i || fmt_s || fmt_b) && !csr_uimm;
  assign need_rs2 = fmt_r || fmt_s || fmt_b;
  assign need_rd  = fmt_r || fmt_i || fmt_u || fmt_j;

  always_comb begin
    alu_sel = alu_none;
    exc_sel = exc_none;
    mem_sel = mem_none;
    case (opcode)
      opc_lui:   begin alu_sel = alu_add; exc_sel = exc_lui; end
      opc_auipc: begin alu_sel = alu_add; exc_sel = exc_auipc; end
      opc_jal:   begin alu_sel = alu_add; exc_sel = exc_jal; end
      opc_jalr: begin
        exc_sel = exc_jalr;
        if (funct3 == 3'b000) alu_sel = alu_add;
      end
      opc_branch: begin
        exc_sel = exc_branch;
        case (funct3)
          3'b000:  alu_sel = alu_beq;
          3'b001:  alu_sel = alu_bne;
          3'b100:  alu_sel = alu_blt;
          3'b101:  alu_sel = alu_bge;
          3'b110:  alu_sel = alu_bltu;
          3'b111:  alu_sel = alu_bgeu;
          default: alu_sel = alu_none;
        endcase
      end
      opc_load: begin
        alu_sel = alu_add;
        exc_sel = exc_load;
        case (funct3)
          3'b000:  mem_sel = mem_lb;
          3'b001:  mem_sel = mem_lh;
          3'b010:  mem_sel = mem_lw;
          3'b011:  mem_sel = mem_ld;
          3'b100:  mem_sel = mem_lbu;
          3'b101:  mem_sel = mem_lhu;
          3'b110:  mem_sel = mem_lwu;
          default: mem_sel = mem_none;
        endcase
      end
      opc_store: begin
        alu_sel = alu_add;
        exc_sel = exc_store;
        case (funct3)
          3'b000:  mem_sel = mem_sb;
          3'b001:  mem_sel = mem_sh;
          3'b010:  mem_sel = mem_sw;
          3'b011:  mem_sel = mem_sd;
          default: mem_sel = mem_none;
        endcase
      end
      opc_op_imm: begin
        exc_sel = exc_opimm;
        case (funct3)
          3'b000: alu_sel = alu_add;
          3'b010: alu_sel = alu_slt;
          3'b011: alu_sel = alu_sltu;
          3'b100: alu_sel = alu_xor;
          3'b110: alu_sel = alu_or;
          3'b111: alu_sel = alu_and;
          // rv64 shamt is 6 bits, so funct7[0] belongs to it
          3'b001: if (funct7[6:1] == 6'b000000) alu_sel = alu_sll;
          default: begin
            if (funct7[6:1] == 6'b000000) alu_sel = alu_srl;
            else if (funct7[6:1] == 6'b010000) alu_sel = alu_sra;
          end
        endcase
      end
      opc_op_imm_32: begin
        exc_sel = exc_opimm32;
        if (funct3 == 3'b000) alu_sel = alu_add;
        else if (funct3 == 3'b001 && funct7 == 7'b0000000) alu_sel = alu_sllw;
        else if (funct3 == 3'b101 && funct7 == 7'b0000000) alu_sel = alu_srlw;
        else if (funct3 == 3'b101 && funct7 == 7'b0100000) alu_sel = alu_sraw;
      end
      opc_op: begin
        exc_sel = exc_op;
        // muldiv (funct7 0000001) is not supported and stays alu_none
        if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000:  alu_sel = alu_add;
            3'b001:  alu_sel = alu_sll;
            3'b010:  alu_sel = alu_slt;
            3'b011:  alu_sel = alu_sltu;
            3'b100:  alu_sel = alu_xor;
            3'b101:  alu_sel = alu_srl;
            3'b110:  alu_sel = alu_or;
            default: alu_sel = alu_and;
          endcase
        end else if (funct7 == 7'b0100000) begin
          if (funct3 == 3'b000) alu_sel = alu_sub;
          else if (funct3 == 3'b101) alu_sel = alu_sra;
        end
      end
      opc_op_32: begin
        exc_sel = exc_op32;
        if (funct7 == 7'b0000000) begin
          if (funct3 == 3'b000) alu_sel = alu_add;
          else if (funct3 == 3'b001) alu_sel = alu_sllw;
          else if (funct3 == 3'b101) alu_sel = alu_srlw;
        end else if (funct7 == 7'b0100000) begin
          if (funct3 == 3'b000) alu_sel = alu_sub;
          else if (funct3 == 3'b101) alu_sel = alu_sraw;
        end
      end
      opc_misc_mem: if (funct3 == 3'b001) mem_sel = mem_fencei;
      opc_system: begin
        if (is_csr) begin
          alu_sel = alu_add;
          exc_sel = exc_csr;
        end else if (is_ebreak) begin
          exc_sel = exc_ebreak;
        end
      end
      default: ;
    endcase
  end

  // set or clear with a zero source never writes, so it is a plain read
  always_comb begin
    case (funct3[1:0])
      2'b01:   csr_sel = csr_write;
      2'b10:   csr_sel = csr_set;
      2'b11:   csr_sel = csr_clear;
      default: csr_sel = csr_none;
    endcase
    if (funct3[1] && rs1 == '0) csr_sel = csr_read;
    if (!is_csr) csr_sel = csr_none;
  end

  always_comb begin
    ctrl_o               = '0;
    ctrl_o.alu_op        = alu_sel;
    ctrl_o.exc_op        = exc_sel;
    ctrl_o.mem_op        = mem_sel;
    ctrl_o.csr_op        = csr_sel;
    ctrl_o.rs1_idx       = need_rs1 ? rs1 : '0;
    ctrl_o.rs2_idx       = need_rs2 ? inst_i[24:20] : '0;
    ctrl_o.rd_idx        = need_rd ? inst_i[11:7] : '0;
    ctrl_o.csr_idx       = is_csr ? inst_i[31:20] : '0;
    ctrl_o.csr_imm_valid = csr_uimm;
    // decode traps override the fetch bits at their positions
    ctrl_o.trap                    = trap_i;
    ctrl_o.trap[trap_mret]         = is_mret;
    ctrl_o.trap[trap_ebreak]       = is_ebreak;
    ctrl_o.trap[trap_ecall_m]      = is_ecall;
    ctrl_o.trap[trap_illegal_inst] = illegal;
  end

endmodule

// ==== imm_gen.sv ====
`timescale 1ns/1ps

module imm_gen (
  input  logic [rv_decode_pkg::inst_len-1:0] inst_i,
  input  rv_decode_pkg::dec_ctrl_t           ctrl_i,
  output rv_decode_pkg::dec_ctrl_t           ctrl_o
);
  import rv_decode_pkg::*;

  opcode_e         opcode;
  logic [xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opcode = opcode_e'(inst_i[6:0]);

  // sign bit is always inst[31]
  assign imm_i = {{(xlen-11){inst_i[31]}}, inst_i[30:20]};
  assign imm_s = {{(xlen-11){inst_i[31]}}, inst_i[30:25], inst_i[11:7]};
  assign imm_b = {{(xlen-12){inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_u = {{(xlen-31){inst_i[31]}}, inst_i[30:12], 12'b0};
  assign imm_j = {{(xlen-20){inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

  always_comb begin
    ctrl_o = ctrl_i;
    case (opcode)
      opc_load, opc_op_imm, opc_op_imm_32, opc_jalr, opc_system: ctrl_o.imm = imm_i;
      opc_store:          ctrl_o.imm = imm_s;
      opc_branch:         ctrl_o.imm = imm_b;
      opc_auipc, opc_lui: ctrl_o.imm = imm_u;
      opc_jal:            ctrl_o.imm = imm_j;
      // r type, fence and unknown opcodes carry no immediate
      default:            ctrl_o.imm = '0;
    endcase
    // uimm sits in the rs1 field
    ctrl_o.csr_imm = ctrl_i.csr_imm_valid ? {{(xlen-5){1'b0}}, inst_i[19:15]} : '0;
  end

  // branch and jump targets stay halfword aligned
  always_comb begin
    if (ctrl_i.exc_op == exc_branch || ctrl_i.exc_op == exc_jal) begin
      assert (!ctrl_o.imm[0]) else $error("odd branch or jump offset");
    end
  end

endmodule

// ==== operand_forward.sv ====
`timescale 1ns/1ps

module operand_forward (
  input  logic [rv_decode_pkg::reg_addr_w-1:0] rs1_idx_i,
  input  logic [rv_decode_pkg::reg_addr_w-1:0] rs2_idx_i,
  input  rv_decode_pkg::bypass_t               ex_byp_i,
  input  rv_decode_pkg::bypass_t               mem_byp_i,
  input  logic                                 ex_is_load_i,
  input  logic [rv_decode_pkg::xlen-1:0]       rs1_data_i,
  input  logic [rv_decode_pkg::xlen-1:0]       rs2_data_i,
  output logic [rv_decode_pkg::xlen-1:0]       rs1_data_o,
  output logic [rv_decode_pkg::xlen-1:0]       rs2_data_o,
  output logic                                 load_use_o
);
  import rv_decode_pkg::*;

  logic rs1_ex_hit, rs1_mem_hit;
  logic rs2_ex_hit, rs2_mem_hit;

  // x0 is hardwired, a write to it must never be forwarded
  function automatic logic hit(input logic [reg_addr_w-1:0] idx,
                               input logic [reg_addr_w-1:0] rd);
    return (idx != '0) && (idx == rd);
  endfunction

  assign rs1_ex_hit  = hit(rs1_idx_i, ex_byp_i.rd_addr);
  assign rs1_mem_hit = hit(rs1_idx_i, mem_byp_i.rd_addr);
  assign rs2_ex_hit  = hit(rs2_idx_i, ex_byp_i.rd_addr);
  assign rs2_mem_hit = hit(rs2_idx_i, mem_byp_i.rd_addr);

  // ex holds the youngest value, then mem, then the register file
  // wb forwarding is done inside the register file
  assign rs1_data_o = rs1_ex_hit  ? ex_byp_i.rd_data  :
                      rs1_mem_hit ? mem_byp_i.rd_data : rs1_data_i;
  assign rs2_data_o = rs2_ex_hit  ? ex_byp_i.rd_data  :
                      rs2_mem_hit ? mem_byp_i.rd_data : rs2_data_i;

  // load data is not ready until mem, so an ex match must wait a cycle
  assign load_use_o = ex_is_load_i && (rs1_ex_hit || rs2_ex_hit);

endmodule

// ==== id_ex_reg.sv ====
`timescale 1ns/1ps

module id_ex_reg (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  valid_i,
  input  logic                  bubble_i,
  input  rv_decode_pkg::id_ex_t pkt_i,
  output rv_decode_pkg::id_ex_t pkt_o
);
  import rv_decode_pkg::*;

  id_ex_t pkt_q;
  logic   load_en;

  assign load_en = valid_i && !bubble_i;

  // a bubble is all zero, which decodes as every op none
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pkt_q <= '0;
    end else if (load_en) begin
      pkt_q       <= pkt_i;
      pkt_q.valid <= 1'b1;
    end else begin
      pkt_q <= '0;
    end
  end

  assign pkt_o = pkt_q;

  // a valid slot without an execute class is a trap, or one of the
  // system and fence encodings that decode leaves unclassified
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (pkt_o.valid && pkt_o.ctrl.exc_op == exc_none) |->
      (pkt_o.ctrl.trap[trap_illegal_inst] ||
       pkt_o.inst[6:0] == opc_system || pkt_o.inst[6:0] == opc_misc_mem))
    else $error("valid id/ex slot with no execute class");

endmodule

// ==== decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 fetch_valid_i,
  input  rv_decode_pkg::fetch_pkt_t            fetch_i,
  input  rv_decode_pkg::bypass_t               ex_byp_i,
  input  rv_decode_pkg::bypass_t               mem_byp_i,
  input  logic                                 ex_is_load_i,
  input  logic [rv_decode_pkg::xlen-1:0]       rs1_data_i,
  input  logic [rv_decode_pkg::xlen-1:0]       rs2_data_i,
  output logic [rv_decode_pkg::reg_addr_w-1:0] rs1_idx_o,
  output logic [rv_decode_pkg::reg_addr_w-1:0] rs2_idx_o,
  output logic                                 stall_o,
  output rv_decode_pkg::id_ex_t                id_ex_o
);
  import rv_decode_pkg::*;

  dec_ctrl_t       field_ctrl;
  dec_ctrl_t       full_ctrl;
  id_ex_t          id_ex_d;
  logic [xlen-1:0] rs1_fwd, rs2_fwd;
  logic            load_use;

  inst_field_decoder u_field_dec (
    .inst_i (fetch_i.inst),
    .trap_i (fetch_i.trap),
    .ctrl_o (field_ctrl)
  );

  imm_gen u_imm_gen (
    .inst_i (fetch_i.inst),
    .ctrl_i (field_ctrl),
    .ctrl_o (full_ctrl)
  );

  // register file is read with the masked indices
  assign rs1_idx_o = field_ctrl.rs1_idx;
  assign rs2_idx_o = field_ctrl.rs2_idx;

  operand_forward u_fwd (
    .rs1_idx_i    (field_ctrl.rs1_idx),
    .rs2_idx_i    (field_ctrl.rs2_idx),
    .ex_byp_i     (ex_byp_i),
    .mem_byp_i    (mem_byp_i),
    .ex_is_load_i (ex_is_load_i),
    .rs1_data_i   (rs1_data_i),
    .rs2_data_i   (rs2_data_i),
    .rs1_data_o   (rs1_fwd),
    .rs2_data_o   (rs2_fwd),
    .load_use_o   (load_use)
  );

  // fetch holds the instruction while this is high
  assign stall_o = fetch_valid_i && load_use;

  assign id_ex_d = '{valid: fetch_valid_i, pc: fetch_i.pc, inst: fetch_i.inst,
                     ctrl: full_ctrl, rs1_data: rs1_fwd, rs2_data: rs2_fwd};

  id_ex_reg u_id_ex (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .valid_i  (fetch_valid_i),
    .bubble_i (load_use),
    .pkt_i    (id_ex_d),
    .pkt_o    (id_ex_o)
  );

endmodule

// ==== tb_decode_model.svh ====
// reference model of the decode stage, written from the encoding tables

function automatic dec_ctrl_t model_decode(input logic [inst_len-1:0] inst,
                                           input logic [trap_len-1:0] trap_in);
  dec_ctrl_t  c;
  logic [6:0] opc;
  logic [2:0] f3;
  logic [6:0] f7;
  logic [4:0] rs1f;
  logic       csr;
  logic       known;
  c = '0;
  opc = inst[6:0];
  f3 = inst[14:12];
  f7 = inst[31:25];
  rs1f = inst[19:15];
  csr = (opc == opc_system) && (f3[1:0] != 2'b00);
  known = 1'b1;
  case (opc)
    opc_lui, opc_auipc: begin
      c.alu_op = alu_add;
      c.exc_op = (opc == opc_lui) ? exc_lui : exc_auipc;
      c.rd_idx = inst[11:7];
      c.imm = {{32{inst[31]}}, inst[31:12], 12'h000};
    end
    opc_jal: begin
      c.alu_op = alu_add;
      c.exc_op = exc_jal;
      c.rd_idx = inst[11:7];
      c.imm = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    end
    opc_jalr: begin
      c.alu_op = (f3 == 3'd0) ? alu_add : alu_none;
      c.exc_op = exc_jalr;
      c.rs1_idx = rs1f;
      c.rd_idx = inst[11:7];
      c.imm = {{52{inst[31]}}, inst[31:20]};
    end
    opc_branch: begin
      c.exc_op = exc_branch;
      c.rs1_idx = rs1f;
      c.rs2_idx = inst[24:20];
      c.imm = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      if (f3 == 3'd0) c.alu_op = alu_beq;
      if (f3 == 3'd1) c.alu_op = alu_bne;
      if (f3 == 3'd4) c.alu_op = alu_blt;
      if (f3 == 3'd5) c.alu_op = alu_bge;
      if (f3 == 3'd6) c.alu_op = alu_bltu;
      if (f3 == 3'd7) c.alu_op = alu_bgeu;
    end
    opc_load: begin
      c.alu_op = alu_add;
      c.exc_op = exc_load;
      c.rs1_idx = rs1f;
      c.rd_idx = inst[11:7];
      c.imm = {{52{inst[31]}}, inst[31:20]};
      if (f3 == 3'd0) c.mem_op = mem_lb;
      if (f3 == 3'd1) c.mem_op = mem_lh;
      if (f3 == 3'd2) c.mem_op = mem_lw;
      if (f3 == 3'd3) c.mem_op = mem_ld;
      if (f3 == 3'd4) c.mem_op = mem_lbu;
      if (f3 == 3'd5) c.mem_op = mem_lhu;
      if (f3 == 3'd6) c.mem_op = mem_lwu;
    end
    opc_store: begin
      c.alu_op = alu_add;
      c.exc_op = exc_store;
      c.rs1_idx = rs1f;
      c.rs2_idx = inst[24:20];
      c.imm = {{52{inst[31]}}, inst[31:25], inst[11:7]};
      if (f3 == 3'd0) c.mem_op = mem_sb;
      if (f3 == 3'd1) c.mem_op = mem_sh;
      if (f3 == 3'd2) c.mem_op = mem_sw;
      if (f3 == 3'd3) c.mem_op = mem_sd;
    end
    opc_op_imm, opc_op_imm_32: begin
      c.exc_op = (opc == opc_op_imm) ? exc_opimm : exc_opimm32;
      c.rs1_idx = rs1f;
      c.rd_idx = inst[11:7];
      c.imm = {{52{inst[31]}}, inst[31:20]};
      if (opc == opc_op_imm) begin
        if (f3 == 3'd0) c.alu_op = alu_add;
        if (f3 == 3'd2) c.alu_op = alu_slt;
        if (f3 == 3'd3) c.alu_op = alu_sltu;
        if (f3 == 3'd4) c.alu_op = alu_xor;
        if (f3 == 3'd6) c.alu_op = alu_or;
        if (f3 == 3'd7) c.alu_op = alu_and;
        // six bit shamt on rv64
        if (f3 == 3'd1 && f7[6:1] == 6'h00) c.alu_op = alu_sll;
        if (f3 == 3'd5 && f7[6:1] == 6'h00) c.alu_op = alu_srl;
        if (f3 == 3'd5 && f7[6:1] == 6'h10) c.alu_op = alu_sra;
      end else begin
        if (f3 == 3'd0) c.alu_op = alu_add;
        if (f3 == 3'd1 && f7 == 7'h00) c.alu_op = alu_sllw;
        if (f3 == 3'd5 && f7 == 7'h00) c.alu_op = alu_srlw;
        if (f3 == 3'd5 && f7 == 7'h20) c.alu_op = alu_sraw;
      end
    end
    opc_op, opc_op_32: begin
      c.exc_op = (opc == opc_op) ? exc_op : exc_op32;
      c.rs1_idx = rs1f;
      c.rs2_idx = inst[24:20];
      c.rd_idx = inst[11:7];
      // funct7 0000001 is muldiv and keeps alu none
      case ({opc == opc_op_32, f7, f3})
        {1'b0, 7'h00, 3'd0}, {1'b1, 7'h00, 3'd0}: c.alu_op = alu_add;
        {1'b0, 7'h20, 3'd0}, {1'b1, 7'h20, 3'd0}: c.alu_op = alu_sub;
        {1'b0, 7'h00, 3'd1}: c.alu_op = alu_sll;
        {1'b0, 7'h00, 3'd2}: c.alu_op = alu_slt;
        {1'b0, 7'h00, 3'd3}: c.alu_op = alu_sltu;
        {1'b0, 7'h00, 3'd4}: c.alu_op = alu_xor;
        {1'b0, 7'h00, 3'd5}: c.alu_op = alu_srl;
        {1'b0, 7'h20, 3'd5}: c.alu_op = alu_sra;
        {1'b0, 7'h00, 3'd6}: c.alu_op = alu_or;
        {1'b0, 7'h00, 3'd7}: c.alu_op = alu_and;
        {1'b1, 7'h00, 3'd1}: c.alu_op = alu_sllw;
        {1'b1, 7'h00, 3'd5}: c.alu_op = alu_srlw;
        {1'b1, 7'h20, 3'd5}: c.alu_op = alu_sraw;
        default: c.alu_op = alu_none;
      endcase
    end
    opc_misc_mem: begin
      if (f3 == 3'd1) c.mem_op = mem_fencei;
    end
    opc_system: begin
      c.rd_idx = inst[11:7];
      c.imm = {{52{inst[31]}}, inst[31:20]};
      c.rs1_idx = (csr && f3[2]) ? 5'd0 : rs1f;
      if (csr) begin
        c.alu_op = alu_add;
        c.exc_op = exc_csr;
        c.csr_idx = inst[31:20];
        c.csr_imm_valid = f3[2];
        c.csr_imm = f3[2] ? {59'd0, rs1f} : 64'd0;
        if (f3[1:0] == 2'b01) c.csr_op = csr_write;
        else if (rs1f == 5'd0) c.csr_op = csr_read;
        else if (f3[1:0] == 2'b10) c.csr_op = csr_set;
        else c.csr_op = csr_clear;
      end else if (f3 == 3'd0 && inst[31:20] == 12'h001) begin
        c.exc_op = exc_ebreak;
      end
    end
    default: known = 1'b0;
  endcase
  c.trap = trap_in;
  c.trap[trap_illegal_inst] = !known;
  c.trap[trap_ecall_m] = (opc == opc_system) && (f3 == 3'd0) && (inst[31:20] == 12'h000);
  c.trap[trap_ebreak]  = (opc == opc_system) && (f3 == 3'd0) && (inst[31:20] == 12'h001);
  c.trap[trap_mret]    = (opc == opc_system) && (f3 == 3'd0) && (inst[31:20] == 12'h302);
  return c;
endfunction

// youngest producer first, x0 never forwarded
function automatic logic [xlen-1:0] model_operand(input logic [reg_addr_w-1:0] idx,
                                                  input bypass_t ex_b,
                                                  input bypass_t mem_b,
                                                  input logic [xlen-1:0] rf_data);
  if (idx == 5'd0) return rf_data;
  if (idx == ex_b.rd_addr) return ex_b.rd_data;
  if (idx == mem_b.rd_addr) return mem_b.rd_data;
  return rf_data;
endfunction

// ==== tb_decode_stage.sv ====
`timescale 1ns/1ps

module tb_decode_stage;
  import rv_decode_pkg::*;

  `include "tb_decode_model.svh"

  localparam int num_cycles = 1500;

  logic            clk_i = 1'b0;
  logic            rst_n_i;
  logic            fetch_valid_i;
  fetch_pkt_t      fetch_i;
  bypass_t         ex_byp_i;
  bypass_t         mem_byp_i;
  logic            ex_is_load_i;
  logic [xlen-1:0] rs1_data_i;
  logic [xlen-1:0] rs2_data_i;
  logic [reg_addr_w-1:0] rs1_idx_o;
  logic [reg_addr_w-1:0] rs2_idx_o;
  logic            stall_o;
  id_ex_t          id_ex_o;

  logic [31:0] lfsr_state;
  id_ex_t      exp_q[$];
  id_ex_t      exp_pkt;
  id_ex_t      next_pkt;
  dec_ctrl_t   exp_ctrl;
  logic        exp_stall;
  logic        held_stall;
  int          errors;
  int          checks;
  opcode_e     opc_list[13] = '{opc_load, opc_store, opc_branch, opc_jalr, opc_jal,
                                opc_misc_mem, opc_op_imm, opc_op, opc_system, opc_auipc,
                                opc_lui, opc_op_imm_32, opc_op_32};

  decode_stage uut (.*);

  initial begin
    forever #4 clk_i = ~clk_i;
  end

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r = {r[62:0], fb};
    end
    return r;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("MISMATCH %s expected %h actual %h at %0t", name, expected, actual, $time);
    end
  endtask

  task automatic compare_packet(input id_ex_t e, input id_ex_t a);
    check_value("valid", 64'(e.valid), 64'(a.valid));
    check_value("pc", e.pc, a.pc);
    check_value("inst", 64'(e.inst), 64'(a.inst));
    check_value("alu_op", 64'(e.ctrl.alu_op), 64'(a.ctrl.alu_op));
    check_value("exc_op", 64'(e.ctrl.exc_op), 64'(a.ctrl.exc_op));
    check_value("mem_op", 64'(e.ctrl.mem_op), 64'(a.ctrl.mem_op));
    check_value("csr_op", 64'(e.ctrl.csr_op), 64'(a.ctrl.csr_op));
    check_value("indices", 64'({e.ctrl.rs1_idx, e.ctrl.rs2_idx, e.ctrl.rd_idx}),
                64'({a.ctrl.rs1_idx, a.ctrl.rs2_idx, a.ctrl.rd_idx}));
    check_value("csr_idx", 64'(e.ctrl.csr_idx), 64'(a.ctrl.csr_idx));
    check_value("imm", e.ctrl.imm, a.ctrl.imm);
    check_value("csr_imm", e.ctrl.csr_imm, a.ctrl.csr_imm);
    check_value("csr_imm_valid", 64'(e.ctrl.csr_imm_valid), 64'(a.ctrl.csr_imm_valid));
    check_value("trap", 64'(e.ctrl.trap), 64'(a.ctrl.trap));
    check_value("rs1_data", e.rs1_data, a.rs1_data);
    check_value("rs2_data", e.rs2_data, a.rs2_data);
  endtask

  // new instruction unless fetch was told to hold, fresh bypass and register data
  task automatic drive_cycle();
    fetch_pkt_t f;
    bypass_t    eb;
    bypass_t    mb;
    logic [1:0] sel;
    f = fetch_i;
    if (!held_stall) begin
      f.pc = rand_bits(64);
      f.trap = 16'(rand_bits(16));
      f.inst = 32'(rand_bits(32));
      f.inst[6:0] = opc_list[4'(rand_bits(8) % 13)];
      sel = 2'(rand_bits(2));
      f.inst[31:25] = (sel == 0) ? 7'h00 : (sel == 1) ? 7'h20 : (sel == 2) ? 7'h01 : f.inst[31:25];
      if (rand_bits(2) == 0) f.inst[19:15] = 5'd0;
      if (f.inst[6:0] == opc_system && rand_bits(1)) begin
        sel = 2'(rand_bits(2));
        f.inst[14:12] = 3'd0;
        f.inst[31:20] = (sel == 0) ? 12'h000 : (sel == 1) ? 12'h001 : 12'h302;
      end
      if (rand_bits(3) == 0) f.inst[6:0] = 7'(rand_bits(7));
    end
    sel = 2'(rand_bits(2));
    eb.rd_addr = (sel == 0) ? f.inst[19:15] : (sel == 1) ? f.inst[24:20] : 5'(rand_bits(5));
    eb.rd_data = rand_bits(64);
    sel = 2'(rand_bits(2));
    mb.rd_addr = (sel == 0) ? f.inst[19:15] : (sel == 1) ? f.inst[24:20] : 5'(rand_bits(5));
    mb.rd_data = rand_bits(64);
    fetch_i <= f;
    fetch_valid_i <= held_stall || (rand_bits(3) != 0);
    ex_byp_i <= eb;
    mem_byp_i <= mb;
    ex_is_load_i <= (rand_bits(2) == 0);
    rs1_data_i <= rand_bits(64);
    rs2_data_i <= rand_bits(64);
  endtask

  // outputs are stable mid cycle, the model is evaluated here
  always @(negedge clk_i) begin
    if (exp_q.size() > 0) begin
      exp_pkt = exp_q.pop_front();
      compare_packet(exp_pkt, id_ex_o);
    end
    exp_ctrl = model_decode(fetch_i.inst, fetch_i.trap);
    exp_stall = fetch_valid_i && ex_is_load_i && (ex_byp_i.rd_addr != 5'd0) &&
                ((exp_ctrl.rs1_idx == ex_byp_i.rd_addr) ||
                 (exp_ctrl.rs2_idx == ex_byp_i.rd_addr));
    check_value("stall", 64'(exp_stall), 64'(stall_o));
    check_value("rs_idx_out", 64'({exp_ctrl.rs1_idx, exp_ctrl.rs2_idx}),
                64'({rs1_idx_o, rs2_idx_o}));
    next_pkt = '0;
    if (rst_n_i && fetch_valid_i && !exp_stall) begin
      next_pkt.valid = 1'b1;
      next_pkt.pc = fetch_i.pc;
      next_pkt.inst = fetch_i.inst;
      next_pkt.ctrl = exp_ctrl;
      next_pkt.rs1_data = model_operand(exp_ctrl.rs1_idx, ex_byp_i, mem_byp_i, rs1_data_i);
      next_pkt.rs2_data = model_operand(exp_ctrl.rs2_idx, ex_byp_i, mem_byp_i, rs2_data_i);
    end
    exp_q.push_back(next_pkt);
    held_stall = exp_stall;
  end

  initial begin
    #(2000 * 8 + 5 * 8);
    $display("watchdog expired before the test sequence completed");
    $display("Test FAILED");
    $finish;
  end

  initial begin
    lfsr_state = 32'hf78403ce;
    errors = 0;
    checks = 0;
    held_stall = 1'b0;
    rst_n_i = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_i = '0;
    ex_byp_i = '0;
    mem_byp_i = '0;
    ex_is_load_i = 1'b0;
    rs1_data_i = '0;
    rs2_data_i = '0;
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    for (int n = 0; n < num_cycles; n++) begin
      @(posedge clk_i);
      drive_cycle();
    end
    @(posedge clk_i);
    fetch_valid_i <= 1'b0;
    repeat (2) @(posedge clk_i);
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+.
rv_decode_pkg.sv
inst_field_decoder.sv
imm_gen.sv
operand_forward.sv
id_ex_reg.sv
decode_stage.sv
tb_decode_stage.sv

// ==== Makefile ====
SRCS = rv_decode_pkg.sv inst_field_decoder.sv imm_gen.sv operand_forward.sv \
       id_ex_reg.sv decode_stage.sv tb_decode_stage.sv tb_decode_model.svh

.PHONY: run clean

run: obj_dir/Vtb_decode_stage
	./obj_dir/Vtb_decode_stage > sim.log 2>&1; cat sim.log
	grep -q "^Test OK$$" sim.log

obj_dir/Vtb_decode_stage: $(SRCS) list.f
	verilator --binary --timing --assert -f list.f --top-module tb_decode_stage \
		-o Vtb_decode_stage

clean:
	rm -rf obj_dir sim.log
